// File: Bender.yml
package:
  name: i3c_target

sources:
  - include_dirs:
      - src
    files:
      - src/i3c_target_pkg.sv
      - src/target_cfg_regs.sv
      - src/bus_monitor.sv
      - src/bus_timers.sv
      - src/bus_rx_flow.sv
      - src/target_fsm.sv
      - src/i3c_target_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/i3c_target_checker.sv
      - tb/tb_i3c_target.sv

// File: project.f
+incdir+src
src/i3c_target_pkg.sv
src/target_cfg_regs.sv
src/bus_monitor.sv
src/bus_timers.sv
src/bus_rx_flow.sv
src/target_fsm.sv
src/i3c_target_top.sv
tb/i3c_target_checker.sv
tb/tb_i3c_target.sv

// File: src/bus_monitor.sv
// I3C bus monitor: SCL/SDA synchronizer and START, repeated START and STOP detection
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_macros.svh"

module bus_monitor
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  target_cfg_t cfg_i,
  input  logic        scl_i,
  input  logic        sda_i,
  output bus_events_t events_o
);

  logic [`I3C_SYNC_STAGES-1:0] scl_sync_q;
  logic [`I3C_SYNC_STAGES-1:0] sda_sync_q;
  logic                        scl_s;
  logic                        sda_s;
  logic                        scl_prev_q;
  logic                        sda_prev_q;
  logic                        scl_high;
  logic                        sda_fall;
  logic                        sda_rise;
  logic                        open_q;
  bus_events_t                 events_d;
  bus_events_t                 events_q;

  assign scl_s = scl_sync_q[`I3C_SYNC_STAGES-1];
  assign sda_s = sda_sync_q[`I3C_SYNC_STAGES-1];

  // Conditions on SDA only count with SCL high in both samples
  assign scl_high = scl_prev_q & scl_s;
  assign sda_fall = sda_prev_q & ~sda_s;
  assign sda_rise = ~sda_prev_q & sda_s;

  always_comb begin
    events_d.scl_posedge = scl_s & ~scl_prev_q;
    events_d.scl_negedge = ~scl_s & scl_prev_q;
    events_d.start       = scl_high & sda_fall & ~open_q;
    events_d.rstart      = scl_high & sda_fall & open_q;
    events_d.stop        = scl_high & sda_rise;
  end

  // Idle bus lines are high, so the flops start high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      open_q     <= 1'b0;
      events_q   <= '0;
    end else if (!cfg_i.enable) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      open_q     <= 1'b0;
      events_q   <= '0;
    end else begin
      scl_sync_q <= {scl_sync_q[`I3C_SYNC_STAGES-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[`I3C_SYNC_STAGES-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
      events_q   <= events_d;
      if (events_d.start) begin
        open_q <= 1'b1;
      end else if (events_d.stop) begin
        open_q <= 1'b0;
      end
    end
  end

  assign events_o = events_q;

endmodule

`default_nettype wire

// File: src/bus_rx_flow.sv
// I3C byte receiver: shifts in SDA on SCL rising edges, MSB first
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_macros.svh"

module bus_rx_flow
  import i3c_target_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  bus_events_t            events_i,
  input  logic                   sda_i,
  input  logic                   restart_i,
  output logic [`I3C_BYTE_W-1:0] byte_o,
  output logic                   byte_done_o
);

  localparam int unsigned CntW = $clog2(`I3C_BYTE_W + 1);

  logic [`I3C_SYNC_STAGES-1:0] sda_sync_q;
  logic                        sda_s;
  logic [`I3C_BYTE_W-1:0]      shift_q;
  logic [CntW-1:0]             cnt_q;
  logic                        sample;
  logic                        done_q;

  // Same depth as the monitor, so samples line up with the SCL events
  assign sda_s = sda_sync_q[`I3C_SYNC_STAGES-1];

  // ACK bit and anything after it wait for restart
  assign sample = events_i.scl_posedge && (cnt_q < CntW'(`I3C_BYTE_W));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sda_sync_q <= '1;
      cnt_q      <= '0;
      done_q     <= 1'b0;
    end else begin
      sda_sync_q <= {sda_sync_q[`I3C_SYNC_STAGES-2:0], sda_i};
      done_q     <= sample && (cnt_q == CntW'(`I3C_BYTE_W - 1));
      if (restart_i) begin
        cnt_q <= '0;
      end else if (sample) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample && !restart_i) begin
      shift_q <= {shift_q[`I3C_BYTE_W-2:0], sda_s};
    end
  end

  assign byte_o      = shift_q;
  assign byte_done_o = done_q;

endmodule

`default_nettype wire

// File: src/bus_timers.sv
// I3C bus timer: raises bus-available after a configured idle time following STOP
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_macros.svh"

module bus_timers
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  target_cfg_t cfg_i,
  input  bus_events_t events_i,
  output logic        bus_available_o
);

  logic [`I3C_TIMER_W-1:0] cnt_q;
  logic                    counting_q;
  logic                    avail_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      counting_q <= 1'b0;
      avail_q    <= 1'b0;
    end else if (!cfg_i.enable || events_i.start || events_i.rstart) begin
      cnt_q      <= '0;
      counting_q <= 1'b0;
      avail_q    <= 1'b0;
    end else if (events_i.stop) begin
      cnt_q      <= '0;
      counting_q <= 1'b1;
      avail_q    <= 1'b0;
    end else if (counting_q && !avail_q) begin
      // Saturate once the idle time is reached
      if (cnt_q == cfg_i.t_bus_available) begin
        avail_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign bus_available_o = avail_q;

endmodule

`default_nettype wire

// File: src/i3c_target_macros.svh
// I3C target front end: shared widths, synchronizer depth and reset defaults
`ifndef I3C_TARGET_MACROS_SVH
`define I3C_TARGET_MACROS_SVH

// Target address, without the RnW bit
`define I3C_ADDR_W 7

// One bus byte
`define I3C_BYTE_W 8

// Bus-available time and its counter
`define I3C_TIMER_W 16

// Configuration register index
`define I3C_CFG_ADDR_W 2

`define I3C_SYNC_STAGES 2

`define I3C_T_AVAIL_RESET 100

`endif

// File: src/i3c_target_pkg.sv
// I3C target front end: bus event, configuration and register index types
`default_nettype none

`include "i3c_target_macros.svh"

package i3c_target_pkg;

  // One cycle of detected bus conditions, each bit a single pulse
  typedef struct packed {
    logic scl_posedge;
    logic scl_negedge;
    logic start;
    logic rstart;
    logic stop;
  } bus_events_t;

  typedef struct packed {
    logic                    enable;
    logic [`I3C_ADDR_W-1:0]  sta_addr;
    logic [`I3C_ADDR_W-1:0]  dyn_addr;
    logic                    dyn_addr_valid;
    logic [`I3C_TIMER_W-1:0] t_bus_available;
  } target_cfg_t;

  typedef enum logic [`I3C_CFG_ADDR_W-1:0] {
    CfgCtrl    = 2'd0,
    CfgStaAddr = 2'd1,
    CfgDynAddr = 2'd2,
    CfgTAvail  = 2'd3
  } cfg_reg_e;

endpackage

`default_nettype wire

// File: src/i3c_target_top.sv
// I3C target front end top level: configuration block and bus logic
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_macros.svh"

module i3c_target_top
  import i3c_target_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    scl_i,
  input  logic                    sda_i,
  output logic                    sda_o,
  input  logic                    cfg_we_i,
  input  cfg_reg_e                cfg_addr_i,
  input  logic [`I3C_TIMER_W-1:0] cfg_wdata_i,
  input  logic                    rx_queue_full_i,
  output logic                    rx_valid_o,
  output logic [`I3C_BYTE_W-1:0]  rx_data_o,
  output logic                    rx_done_o,
  output logic                    bus_start_o,
  output logic                    bus_rstart_o,
  output logic                    bus_stop_o,
  output logic [`I3C_BYTE_W-1:0]  bus_addr_o,
  output logic                    bus_addr_valid_o,
  output logic                    bus_available_o
);

  target_cfg_t            cfg;
  bus_events_t            events;
  logic [`I3C_BYTE_W-1:0] rx_byte;
  logic                   rx_byte_done;
  logic                   rx_restart;

  target_cfg_regs i_target_cfg_regs (
    .clk_i,
    .rst_ni,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .cfg_o       (cfg)
  );

  bus_monitor i_bus_monitor (
    .clk_i,
    .rst_ni,
    .cfg_i    (cfg),
    .scl_i,
    .sda_i,
    .events_o (events)
  );

  bus_timers i_bus_timers (
    .clk_i,
    .rst_ni,
    .cfg_i           (cfg),
    .events_i        (events),
    .bus_available_o
  );

  bus_rx_flow i_bus_rx_flow (
    .clk_i,
    .rst_ni,
    .events_i    (events),
    .sda_i,
    .restart_i   (rx_restart),
    .byte_o      (rx_byte),
    .byte_done_o (rx_byte_done)
  );

  target_fsm i_target_fsm (
    .clk_i,
    .rst_ni,
    .cfg_i            (cfg),
    .events_i         (events),
    .byte_i           (rx_byte),
    .byte_done_i      (rx_byte_done),
    .rx_queue_full_i,
    .rx_restart_o     (rx_restart),
    .sda_o,
    .rx_valid_o,
    .rx_data_o,
    .rx_done_o,
    .bus_addr_o,
    .bus_addr_valid_o
  );

  // Bus conditions straight from the monitor
  assign bus_start_o  = events.start;
  assign bus_rstart_o = events.rstart;
  assign bus_stop_o   = events.stop;

endmodule

`default_nettype wire

// File: src/target_cfg_regs.sv
// Configuration registers of the I3C target, written through a strobe port
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_macros.svh"

module target_cfg_regs
  import i3c_target_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cfg_we_i,
  input  cfg_reg_e                cfg_addr_i,
  input  logic [`I3C_TIMER_W-1:0] cfg_wdata_i,
  output target_cfg_t             cfg_o
);

  target_cfg_t cfg_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q.enable          <= 1'b0;
      cfg_q.sta_addr        <= '0;
      cfg_q.dyn_addr        <= '0;
      cfg_q.dyn_addr_valid  <= 1'b0;
      cfg_q.t_bus_available <= `I3C_TIMER_W'(`I3C_T_AVAIL_RESET);
    end else if (cfg_we_i) begin
      unique case (cfg_addr_i)
        CfgCtrl: begin
          cfg_q.enable <= cfg_wdata_i[0];
        end
        CfgStaAddr: begin
          cfg_q.sta_addr <= cfg_wdata_i[`I3C_ADDR_W-1:0];
        end
        // Valid flag sits just above the address bits
        CfgDynAddr: begin
          cfg_q.dyn_addr       <= cfg_wdata_i[`I3C_ADDR_W-1:0];
          cfg_q.dyn_addr_valid <= cfg_wdata_i[`I3C_ADDR_W];
        end
        CfgTAvail: begin
          cfg_q.t_bus_available <= cfg_wdata_i;
        end
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: src/target_fsm.sv
// I3C target FSM: address match, ACK/NACK on SDA, write data push and completion
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_macros.svh"

module target_fsm
  import i3c_target_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  target_cfg_t            cfg_i,
  input  bus_events_t            events_i,
  input  logic [`I3C_BYTE_W-1:0] byte_i,
  input  logic                   byte_done_i,
  input  logic                   rx_queue_full_i,
  output logic                   rx_restart_o,
  output logic                   sda_o,
  output logic                   rx_valid_o,
  output logic [`I3C_BYTE_W-1:0] rx_data_o,
  output logic                   rx_done_o,
  output logic [`I3C_BYTE_W-1:0] bus_addr_o,
  output logic                   bus_addr_valid_o
);

  typedef enum logic [2:0] {Idle, Addr, AddrAck, Data, DataAck, Ignore} state_e;

  state_e                 state_q, state_d;
  logic                   ack_q, ack_d;
  logic                   ack_bit_q, ack_bit_d;
  logic                   sda_q, sda_d;
  logic                   accepted_q, accepted_d;
  logic                   rx_valid_q, rx_valid_d;
  logic                   rx_done_q, rx_done_d;
  logic                   addr_valid_q, addr_valid_d;
  logic [`I3C_ADDR_W-1:0] own_addr;
  logic                   addr_match;
  logic [`I3C_BYTE_W-1:0] rx_data_q;
  logic [`I3C_BYTE_W-1:0] bus_addr_q;

  // Dynamic address wins once assigned; only writes are accepted
  assign own_addr   = cfg_i.dyn_addr_valid ? cfg_i.dyn_addr : cfg_i.sta_addr;
  assign addr_match = (byte_i[`I3C_BYTE_W-1:1] == own_addr) && !byte_i[0];

  always_comb begin
    state_d      = state_q;
    ack_d        = ack_q;
    ack_bit_d    = ack_bit_q;
    sda_d        = sda_q;
    accepted_d   = accepted_q;
    rx_valid_d   = 1'b0;
    rx_done_d    = 1'b0;
    addr_valid_d = 1'b0;
    rx_restart_o = 1'b0;
    unique case (state_q)
      Addr: begin
        if (byte_done_i) begin
          addr_valid_d = 1'b1;
          ack_d        = addr_match;
          ack_bit_d    = 1'b0;
          state_d      = AddrAck;
        end
      end
      Data: begin
        if (byte_done_i) begin
          ack_d      = !rx_queue_full_i;
          rx_valid_d = !rx_queue_full_i;
          accepted_d = accepted_q | !rx_queue_full_i;
          ack_bit_d  = 1'b0;
          state_d    = DataAck;
        end
      end
      // First falling edge opens the ACK bit, second one closes it
      AddrAck, DataAck: begin
        if (events_i.scl_negedge && !ack_bit_q) begin
          sda_d     = !ack_q;
          ack_bit_d = 1'b1;
        end else if (events_i.scl_negedge) begin
          sda_d        = 1'b1;
          ack_bit_d    = 1'b0;
          rx_restart_o = 1'b1;
          state_d      = (state_q == AddrAck && !ack_q) ? Ignore : Data;
        end
      end
      default: begin
        state_d = state_q;
      end
    endcase
    if (events_i.stop) begin
      state_d    = Idle;
      sda_d      = 1'b1;
      ack_bit_d  = 1'b0;
      rx_done_d  = accepted_q;
      accepted_d = 1'b0;
    end else if (events_i.start || events_i.rstart) begin
      state_d      = Addr;
      sda_d        = 1'b1;
      ack_bit_d    = 1'b0;
      rx_restart_o = 1'b1;
      if (events_i.start) begin
        accepted_d = 1'b0;
      end
    end
    if (!cfg_i.enable) begin
      state_d      = Idle;
      ack_d        = 1'b0;
      ack_bit_d    = 1'b0;
      sda_d        = 1'b1;
      accepted_d   = 1'b0;
      rx_valid_d   = 1'b0;
      rx_done_d    = 1'b0;
      addr_valid_d = 1'b0;
      rx_restart_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      ack_q        <= 1'b0;
      ack_bit_q    <= 1'b0;
      sda_q        <= 1'b1;
      accepted_q   <= 1'b0;
      rx_valid_q   <= 1'b0;
      rx_done_q    <= 1'b0;
      addr_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      ack_q        <= ack_d;
      ack_bit_q    <= ack_bit_d;
      sda_q        <= sda_d;
      accepted_q   <= accepted_d;
      rx_valid_q   <= rx_valid_d;
      rx_done_q    <= rx_done_d;
      addr_valid_q <= addr_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_valid_d) begin
      rx_data_q <= byte_i;
    end
    if (addr_valid_d) begin
      bus_addr_q <= byte_i;
    end
  end

  assign sda_o            = sda_q;
  assign rx_valid_o       = rx_valid_q;
  assign rx_data_o        = rx_data_q;
  assign rx_done_o        = rx_done_q;
  assign bus_addr_o       = bus_addr_q;
  assign bus_addr_valid_o = addr_valid_q;

endmodule

`default_nettype wire

// File: tb/i3c_target_checker.sv
// I3C target checker: concurrent assertions on bus conditions, RX pushes and bus-available
`timescale 1ns/1ps
`default_nettype none

module i3c_target_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic start_i,
  input logic stop_i,
  input logic rx_valid_i,
  input logic queue_full_i,
  input logic available_i
);

  int fail_cnt = 0;

  start_stop_apart: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(start_i && stop_i))
    else begin
      $error("START and STOP pulsed in the same cycle");
      fail_cnt = fail_cnt + 1;
    end

  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_i |-> !queue_full_i)
    else begin
      $error("RX push while the queue is full");
      fail_cnt = fail_cnt + 1;
    end

  // Bus is busy again right after a START
  start_clears_available: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |=> !available_i)
    else begin
      $error("bus-available still high the cycle after START");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind i3c_target_top i3c_target_checker i_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .start_i      (bus_start_o),
  .stop_i       (bus_stop_o),
  .rx_valid_i   (rx_valid_o),
  .queue_full_i (rx_queue_full_i),
  .available_i  (bus_available_o)
);

`default_nettype wire

// File: tb/tb_i3c_target.sv
// Testbench for the I3C target front end: bus frames, reference model and checks
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_macros.svh"

module tb_i3c_target
  import i3c_target_pkg::*;
();

  localparam int max_bytes    = 10;
  localparam int byte_clks    = 9 * 16;
  // START, repeated START and STOP holds plus address and data bytes
  localparam int frame_clks   = 8 + 24 + 24 + (max_bytes + 2) * byte_clks;
  localparam int num_frames   = 8;
  localparam int timeout_clks = num_frames * frame_clks + 1000;

  typedef struct packed {
    logic addr_ack;
    logic data_ack;
    logic done;
  } outcome_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    scl;
  logic                    sda_drv;
  logic                    sda_bus;
  logic                    sda_out;
  logic                    cfg_we;
  cfg_reg_e                cfg_addr;
  logic [`I3C_TIMER_W-1:0] cfg_wdata;
  logic                    rx_queue_full;
  logic                    rx_valid;
  logic [`I3C_BYTE_W-1:0]  rx_data;
  logic                    rx_done;
  logic                    bus_start;
  logic                    bus_rstart;
  logic                    bus_stop;
  logic [`I3C_BYTE_W-1:0]  bus_addr;
  logic                    bus_addr_valid;
  logic                    bus_available;

  logic [`I3C_BYTE_W-1:0]  got_data[$];
  logic [`I3C_BYTE_W-1:0]  got_addr[$];
  int                      done_cnt = 0;
  int                      start_cnt = 0;
  int                      rstart_cnt = 0;
  int                      stop_cnt = 0;
  int                      err_cnt = 0;
  int                      test_cnt = 0;
  int                      test_fail_cnt = 0;
  int                      cycle_cnt = 0;
  int                      stop_cycle = 0;
  integer                  seed;
  logic [`I3C_ADDR_W-1:0]  model_sta;
  logic [`I3C_ADDR_W-1:0]  model_dyn;
  logic                    model_dyn_valid;

  // Open-drain bus, wired-AND of controller and target
  assign sda_bus = sda_drv & sda_out;

  i3c_target_top i_i3c_target_top (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .scl_i            (scl),
    .sda_i            (sda_bus),
    .sda_o            (sda_out),
    .cfg_we_i         (cfg_we),
    .cfg_addr_i       (cfg_addr),
    .cfg_wdata_i      (cfg_wdata),
    .rx_queue_full_i  (rx_queue_full),
    .rx_valid_o       (rx_valid),
    .rx_data_o        (rx_data),
    .rx_done_o        (rx_done),
    .bus_start_o      (bus_start),
    .bus_rstart_o     (bus_rstart),
    .bus_stop_o       (bus_stop),
    .bus_addr_o       (bus_addr),
    .bus_addr_valid_o (bus_addr_valid),
    .bus_available_o  (bus_available)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_clks) begin
      $display("Timeout: run did not complete within %0d cycles", timeout_clks);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Records pushes, address reports and bus conditions
  always @(negedge clk_i) begin
    if (rx_valid) begin
      got_data.push_back(rx_data);
    end
    if (bus_addr_valid) begin
      got_addr.push_back(bus_addr);
    end
    if (bus_stop) begin
      stop_cycle = cycle_cnt;
    end
    done_cnt   = done_cnt + rx_done;
    start_cnt  = start_cnt + bus_start;
    rstart_cnt = rstart_cnt + bus_rstart;
    stop_cnt   = stop_cnt + bus_stop;
  end

  function automatic outcome_t predict(input logic [`I3C_ADDR_W-1:0] addr, input logic rnw,
                                       input logic [`I3C_ADDR_W-1:0] sta,
                                       input logic [`I3C_ADDR_W-1:0] dyn,
                                       input logic dyn_valid, input logic full,
                                       input int nbytes);
    outcome_t               res;
    logic [`I3C_ADDR_W-1:0] own;
    own          = dyn_valid ? dyn : sta;
    res.addr_ack = (addr == own) && !rnw;
    res.data_ack = res.addr_ack && !full;
    res.done     = res.data_ack && (nbytes > 0);
    return res;
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s %s: expected %0h, actual %0h", test, what, exp, act);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic report_test(input string test, input int errs_before);
    test_cnt = test_cnt + 1;
    if (err_cnt == errs_before) begin
      $display("Test %s: ok", test);
    end else begin
      test_fail_cnt = test_fail_cnt + 1;
      $display("Test %s: %0d errors", test, err_cnt - errs_before);
    end
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic write_cfg(input cfg_reg_e addr, input logic [`I3C_TIMER_W-1:0] data);
    @(negedge clk_i);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk_i);
    cfg_we = 1'b0;
    if (addr == CfgStaAddr) begin
      model_sta = data[`I3C_ADDR_W-1:0];
    end else if (addr == CfgDynAddr) begin
      model_dyn       = data[`I3C_ADDR_W-1:0];
      model_dyn_valid = data[`I3C_ADDR_W];
    end
  endtask

  // Cleared on a rising edge so the recorder never writes at the same time
  task automatic clear_records();
    @(posedge clk_i);
    got_data.delete();
    got_addr.delete();
    done_cnt   = 0;
    start_cnt  = 0;
    rstart_cnt = 0;
    stop_cnt   = 0;
    @(negedge clk_i);
  endtask

  // SDA only moves in the middle of the SCL low phase
  task automatic clock_bit(input logic bit_val, output logic seen);
    wait_clks(4);
    sda_drv = bit_val;
    wait_clks(4);
    scl = 1'b1;
    wait_clks(4);
    seen = sda_bus;
    wait_clks(4);
    scl = 1'b0;
  endtask

  task automatic send_byte(input logic [`I3C_BYTE_W-1:0] data, output logic ack);
    logic seen;
    for (int i = `I3C_BYTE_W - 1; i >= 0; i = i - 1) begin
      clock_bit(data[i], seen);
    end
    clock_bit(1'b1, seen);
    ack = !seen;
  endtask

  task automatic send_start();
    sda_drv = 1'b0;
    wait_clks(8);
    scl = 1'b0;
  endtask

  task automatic send_rstart();
    wait_clks(4);
    sda_drv = 1'b1;
    wait_clks(4);
    scl = 1'b1;
    wait_clks(8);
    sda_drv = 1'b0;
    wait_clks(8);
    scl = 1'b0;
  endtask

  task automatic send_stop();
    wait_clks(4);
    sda_drv = 1'b0;
    wait_clks(4);
    scl = 1'b1;
    wait_clks(8);
    sda_drv = 1'b1;
    wait_clks(8);
  endtask

  task automatic run_frame(input string test, input logic [`I3C_ADDR_W-1:0] addr,
                           input logic rnw, input int nbytes, input logic full,
                           input logic with_rstart);
    outcome_t               exp;
    logic [`I3C_BYTE_W-1:0] addr_byte;
    logic [`I3C_BYTE_W-1:0] sent[max_bytes];
    logic                   ack;
    int                     errs_before;
    int                     n_push;
    int                     rnd;
    errs_before = err_cnt;
    exp         = predict(addr, rnw, model_sta, model_dyn, model_dyn_valid, full, nbytes);
    addr_byte   = {addr, rnw};
    for (int i = 0; i < nbytes; i = i + 1) begin
      rnd     = $random(seed);
      sent[i] = rnd[`I3C_BYTE_W-1:0];
    end
    clear_records();
    rx_queue_full = full;
    send_start();
    if (with_rstart) begin
      send_byte(addr_byte, ack);
      check_value(test, "first address ack", exp.addr_ack, ack);
      send_rstart();
    end
    send_byte(addr_byte, ack);
    check_value(test, "address ack", exp.addr_ack, ack);
    for (int i = 0; i < nbytes; i = i + 1) begin
      send_byte(sent[i], ack);
      check_value(test, "data ack", exp.data_ack, ack);
    end
    send_stop();
    rx_queue_full = 1'b0;
    @(posedge clk_i);
    check_value(test, "start pulses", 1, start_cnt);
    check_value(test, "repeated start pulses", with_rstart, rstart_cnt);
    check_value(test, "stop pulses", 1, stop_cnt);
    check_value(test, "address reports", with_rstart ? 2 : 1, got_addr.size());
    for (int i = 0; i < got_addr.size(); i = i + 1) begin
      check_value(test, "reported address", addr_byte, got_addr[i]);
    end
    n_push = exp.data_ack ? nbytes : 0;
    check_value(test, "pushed bytes", n_push, got_data.size());
    if (got_data.size() == n_push) begin
      for (int i = 0; i < n_push; i = i + 1) begin
        check_value(test, "pushed data", sent[i], got_data[i]);
      end
    end
    check_value(test, "completion pulses", exp.done, done_cnt);
    report_test(test, errs_before);
  endtask

  task automatic run_avail_test(input string test, input logic [`I3C_TIMER_W-1:0] t_avail);
    int errs_before;
    errs_before = err_cnt;
    write_cfg(CfgTAvail, t_avail);
    send_start();
    send_stop();
    // Idle time counts from the STOP pulse
    while (cycle_cnt < stop_cycle + t_avail + 4) begin
      @(negedge clk_i);
    end
    check_value(test, "available after idle", 1, bus_available);
    send_start();
    wait_clks(2);
    check_value(test, "available after start", 0, bus_available);
    send_stop();
    report_test(test, errs_before);
  endtask

  initial begin
    seed            = 40;
    scl             = 1'b1;
    sda_drv         = 1'b1;
    cfg_we          = 1'b0;
    cfg_addr        = CfgCtrl;
    cfg_wdata       = '0;
    rx_queue_full   = 1'b0;
    model_sta       = '0;
    model_dyn       = '0;
    model_dyn_valid = 1'b0;
    rst_ni          = 1'b0;
    wait_clks(2);
    rst_ni = 1'b1;
    write_cfg(CfgStaAddr, 16'h002a);
    write_cfg(CfgCtrl, 16'h0001);
    run_frame("static_rstart", 7'h2a, 1'b0, 3, 1'b0, 1'b1);
    // Valid bit plus address 0x31
    write_cfg(CfgDynAddr, 16'h00b1);
    run_frame("dyn_write", 7'h31, 1'b0, max_bytes, 1'b0, 1'b0);
    run_frame("static_after_dyn", 7'h2a, 1'b0, 2, 1'b0, 1'b0);
    run_frame("other_addr", 7'h15, 1'b0, 2, 1'b0, 1'b0);
    run_frame("own_read", 7'h31, 1'b1, 2, 1'b0, 1'b0);
    run_frame("queue_full", 7'h31, 1'b0, 3, 1'b1, 1'b0);
    run_avail_test("bus_available", 16'd10);
    if (i_i3c_target_top.i_checker.fail_cnt != 0) begin
      $display("Checker assertions failed %0d times", i_i3c_target_top.i_checker.fail_cnt);
      err_cnt = err_cnt + i_i3c_target_top.i_checker.fail_cnt;
    end
    $display("Tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
